/* project.f */
src/ipod_pkg.sv
src/player_control.sv
src/sample_rate_gen.sv
src/flash_fetch.sv
src/ipod_top.sv
testbench/ipod_sva.sv
testbench/tb_ipod.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ipod playback testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_ipod -o sim_ipod
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_ipod > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0

/* testbench/tb_ipod.sv */
`timescale 1ns/1ns

module tb_ipod
  import ipod_pkg::*;
();

  localparam int max_cycles  = 400000;
  localparam int sample_wait = 5000;

  logic        CLK_50M = 1'b0;
  logic        rst_n;
  key_event_t  key;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  flash_addr_t flash_address;
  logic        flash_waitrequest   = 1'b1;
  flash_word_t flash_readdata      = '0;
  logic        flash_readdatavalid = 1'b0;
  sample_out_t sample;
  rate_count_t rate_count;

  int mismatch_count  = 0;
  int fail_count      = 0;
  int protocol_errors = 0;
  int cycle           = 0;

  // Samples with their cycle stamps, and accepted read addresses
  audio_sample_t sample_q[$];
  int            stamp_q[$];
  int            stamp_log[$];
  flash_addr_t   addr_q[$];

  // Expected playback position
  flash_addr_t exp_addr;
  logic        exp_upper;
  logic        exp_held;
  logic        exp_backward;

  // Flash model state
  logic [31:0] rng_state  = 32'h161e_c4ba;
  logic        read_busy  = 1'b0;
  logic        in_request = 1'b0;
  int          wait_left;
  int          delay_left;
  flash_addr_t pend_addr;

  ipod_top i_ipod_top (.*);

  always #10 CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
    if (cycle >= max_cycles)
    begin
      $display("Error: tests still running after %0d cycles", max_cycles);
      $display("Errors: %0d mismatches, %0d check failures, %0d flash protocol errors",
               mismatch_count, fail_count, protocol_errors);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ====================
  // Flash model
  // ====================
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // Lower half is the address, upper half the address xor A5C3
  function automatic flash_word_t flash_word(input flash_addr_t a);
    return {a[15:0] ^ 16'hA5C3, a[15:0]};
  endfunction

  function automatic audio_sample_t expected_sample(input flash_addr_t a, input logic upper);
    logic [15:0] half;
    half = upper ? (a[15:0] ^ 16'hA5C3) : a[15:0];
    return half[15:8];
  endfunction

  // 0 to 3 wait states, data 1 to 4 cycles after acceptance
  always @(negedge CLK_50M)
  begin
    flash_readdatavalid = 1'b0;
    flash_waitrequest   = 1'b1;
    if (!rst_n)
    begin
      read_busy  = 1'b0;
      in_request = 1'b0;
    end
    else if (read_busy)
    begin
      if (flash_read)
      begin
        $display("Error at %0t: second flash read while one is outstanding", $time);
        protocol_errors++;
      end
      if (delay_left == 0)
      begin
        flash_readdatavalid = 1'b1;
        flash_readdata      = flash_word(pend_addr);
        read_busy           = 1'b0;
      end
      else
        delay_left--;
    end
    else if (flash_read)
    begin
      if (!in_request)
      begin
        rng_state  = next_random(rng_state);
        wait_left  = int'(rng_state[1:0]);
        delay_left = int'(rng_state[9:8]);
        in_request = 1'b1;
      end
      if (wait_left == 0)
      begin
        // Taken by the DUT on the coming rising edge
        flash_waitrequest = 1'b0;
        pend_addr         = flash_address;
        addr_q.push_back(flash_address);
        read_busy         = 1'b1;
        in_request        = 1'b0;
      end
      else
        wait_left--;
    end
  end

  always @(negedge CLK_50M)
  begin
    if (sample.valid)
    begin
      sample_q.push_back(sample.data);
      stamp_q.push_back(cycle);
    end
  end

  // ====================
  // Drive and compare
  // ====================
  task automatic apply_reset;
    @(negedge CLK_50M);
    rst_n       = 1'b0;
    key         = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    repeat (3) @(negedge CLK_50M);
    rst_n = 1'b1;
    @(posedge CLK_50M);
    sample_q.delete();
    stamp_q.delete();
    stamp_log.delete();
    addr_q.delete();
  endtask

  task automatic press_key(input ascii_t code);
    @(negedge CLK_50M);
    key = '{valid: 1'b1, code: code};
    @(negedge CLK_50M);
    key = '0;
  endtask

  task automatic pulse_speed(input logic up, input logic down, input logic restore);
    @(negedge CLK_50M);
    speed_up    = up;
    speed_down  = down;
    speed_reset = restore;
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
  endtask

  task automatic check_sample(input audio_sample_t exp, input audio_sample_t got,
                              input string name);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic check_rate(input rate_count_t exp, input rate_count_t got, input string name);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic check_addr(input flash_addr_t exp, input flash_addr_t got, input string name);
    if (got !== exp)
    begin
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  task automatic check_interval(input int exp, input int got, input string name);
    if (got != exp)
    begin
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      mismatch_count++;
    end
  endtask

  // Forward goes lower then upper and backward goes upper then lower
  task automatic step_position;
    if (exp_upper == exp_backward)
      exp_held = 1'b1;
    else if (exp_backward)
    begin
      exp_held = 1'b0;
      exp_addr = (exp_addr == '0) ? flash_last_addr : exp_addr - 23'd1;
    end
    else
    begin
      exp_held = 1'b0;
      exp_addr = (exp_addr == flash_last_addr) ? '0 : exp_addr + 23'd1;
    end
    exp_upper = !exp_upper;
  endtask

  task automatic set_position(input flash_addr_t a, input logic upper, input logic backward);
    exp_addr     = a;
    exp_upper    = upper;
    exp_backward = backward;
    exp_held     = 1'b0;
  endtask

  // A word not yet held must have been read from flash first
  task automatic check_next_samples(input int n);
    int i;
    int waited;
    for (i = 0; i < n; i++)
    begin
      waited = 0;
      while (sample_q.size() == 0 && waited < sample_wait)
      begin
        @(posedge CLK_50M);
        waited++;
      end
      if (sample_q.size() == 0)
      begin
        $display("Error at %0t: sample %0d of %0d never arrived", $time, i + 1, n);
        fail_count++;
        return;
      end
      if (!exp_held)
      begin
        if (addr_q.size() == 0)
        begin
          $display("Error at %0t: no flash read before sample of word %h", $time, exp_addr);
          fail_count++;
        end
        else
          check_addr(exp_addr, addr_q.pop_front(), "flash_address");
      end
      check_sample(expected_sample(exp_addr, exp_upper), sample_q.pop_front(), "sample.data");
      stamp_log.push_back(stamp_q.pop_front());
      step_position();
    end
  endtask

  task automatic check_no_leftovers(input string test);
    if (sample_q.size() != 0 || addr_q.size() != 0)
    begin
      $display("Error at %0t: %s ended with %0d unexpected samples and %0d unexpected reads",
               $time, test, sample_q.size(), addr_q.size());
      fail_count++;
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_state;
    apply_reset();
    repeat (3000) @(negedge CLK_50M);
    check_rate(rate_default, rate_count, "rate_count");
    check_no_leftovers("reset state");
  endtask

  task automatic test_forward_play;
    apply_reset();
    set_position('0, 1'b0, 1'b0);
    press_key(key_play);
    check_next_samples(12);
    check_no_leftovers("forward play");
  endtask

  // Position after reset is word 0 lower half so backward first plays that half
  task automatic test_backward_restart;
    apply_reset();
    set_position('0, 1'b0, 1'b1);
    press_key(key_backward);
    press_key(key_play);
    check_next_samples(5);
    press_key(key_restart);
    set_position(flash_last_addr, 1'b1, 1'b1);
    check_next_samples(3);
    check_no_leftovers("backward and restart");
  endtask

  task automatic test_pause_resume;
    int waited;
    apply_reset();
    set_position('0, 1'b0, 1'b0);
    press_key(key_play);
    check_next_samples(4);
    // Pause while the next word is being fetched
    waited = 0;
    while (!flash_read && waited < sample_wait)
    begin
      @(negedge CLK_50M);
      waited++;
    end
    if (!flash_read)
    begin
      $display("Error at %0t: no flash read started before pause", $time);
      fail_count++;
    end
    press_key(key_pause);
    repeat (3 * (rate_default + 1)) @(negedge CLK_50M);
    // The fetch in flight still delivers its sample
    if (sample_q.size() != 1)
    begin
      $display("Error at %0t: %0d samples arrived after pause, expected only the one in flight",
               $time, sample_q.size());
      fail_count++;
    end
    check_next_samples(sample_q.size());
    press_key(8'h58);
    press_key(8'h65);
    press_key(8'h00);
    @(negedge CLK_50M);
    key = '{valid: 1'b0, code: key_play};
    @(negedge CLK_50M);
    key = '0;
    repeat (3 * (rate_default + 1)) @(negedge CLK_50M);
    check_no_leftovers("pause with unknown keys");
    press_key(key_play);
    check_next_samples(3);
    press_key(8'h51);
    check_next_samples(3);
    check_no_leftovers("pause and resume");
  endtask

  task automatic test_speed_control;
    int i;
    int fast_rate;
    apply_reset();
    set_position('0, 1'b0, 1'b0);
    fast_rate = int'(rate_default) - 5 * int'(rate_step);
    for (i = 0; i < 5; i++)
      pulse_speed(1'b1, 1'b0, 1'b0);
    check_rate(rate_count_t'(fast_rate), rate_count, "rate_count");
    press_key(key_play);
    check_next_samples(6);
    // Second halves are samples 1, 3 and 5
    if (stamp_log.size() >= 6)
    begin
      check_interval(2 * (fast_rate + 1), stamp_log[3] - stamp_log[1], "second half gap");
      check_interval(2 * (fast_rate + 1), stamp_log[5] - stamp_log[3], "second half gap");
    end
    press_key(key_pause);
    for (i = 0; i < 600; i++)
      pulse_speed(1'b1, 1'b0, 1'b0);
    check_rate(rate_min, rate_count, "rate_count");
    for (i = 0; i < 600; i++)
      pulse_speed(1'b0, 1'b1, 1'b0);
    check_rate(rate_max, rate_count, "rate_count");
    pulse_speed(1'b1, 1'b0, 1'b1);
    check_rate(rate_default, rate_count, "rate_count");
    check_no_leftovers("speed control");
  endtask

  initial
  begin
    rst_n       = 1'b0;
    key         = '0;
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    test_reset_state();
    test_forward_play();
    test_backward_restart();
    test_pause_resume();
    test_speed_control();
    $display("Errors: %0d mismatches, %0d check failures, %0d flash protocol errors",
             mismatch_count, fail_count, protocol_errors);
    if (mismatch_count == 0 && fail_count == 0 && protocol_errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* testbench/ipod_sva.sv */
`timescale 1ns/1ns

module ipod_sva
  import ipod_pkg::*;
(
  input logic        CLK_50M,
  input logic        rst_n,
  input logic        flash_read,
  input flash_addr_t flash_address,
  input logic        flash_waitrequest,
  input sample_out_t sample,
  input rate_count_t rate_count
);

  // Avalon request stays put while the slave stalls it
  a_request_held: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address)
  ) else $error("flash read or address changed under waitrequest");

  a_reset_quiet: assert property (
    @(posedge CLK_50M) !rst_n |=> !flash_read && !sample.valid
  ) else $error("flash read or sample valid high right after reset");

  a_rate_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    rate_count >= rate_min && rate_count <= rate_max
  ) else $error("rate count %0d outside its limits", rate_count);

endmodule

// Flash port, audio out and rate count all meet at the top level
bind ipod_top ipod_sva i_ipod_sva (
  .CLK_50M           (CLK_50M),
  .rst_n             (rst_n),
  .flash_read        (flash_read),
  .flash_address     (flash_address),
  .flash_waitrequest (flash_waitrequest),
  .sample            (sample),
  .rate_count        (rate_count)
);

/* src/ipod_top.sv */
`timescale 1ns/1ns

module ipod_top
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst_n,

  // Keyboard and speed buttons
  input  key_event_t  key,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,

  // Avalon flash port
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,

  // Audio out and rate display
  output sample_out_t sample,
  output rate_count_t rate_count
);

  play_ctrl_t ctrl;
  logic       sample_tick;

  // ====================
  // Pipeline
  // ====================
  player_control i_player_control (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .key     (key),
    .ctrl    (ctrl)
  );

  sample_rate_gen i_sample_rate_gen (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .rate_count  (rate_count),
    .sample_tick (sample_tick)
  );

  flash_fetch i_flash_fetch (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .ctrl                (ctrl),
    .sample_tick         (sample_tick),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample)
  );

endmodule

/* src/flash_fetch.sv */
`timescale 1ns/1ns

module flash_fetch
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  play_ctrl_t  ctrl,
  input  logic        sample_tick,
  output logic        flash_read,
  output flash_addr_t flash_address,
  input  logic        flash_waitrequest,
  input  flash_word_t flash_readdata,
  input  logic        flash_readdatavalid,
  output sample_out_t sample
);

  fetch_state_t state;

  // Position of the next sample to play
  flash_addr_t word_addr;
  logic        upper_half;

  // word_reg holds the data of word_addr when word_held is set
  logic        word_held;
  flash_word_t word_reg;

  logic        restart_pending;

  // Position step signals
  logic        same_word;
  flash_addr_t next_addr;
  logic        tick_ok;

  // ====================
  // Position step
  // ====================

  // Forward goes lower then upper, backward goes upper then lower
  assign same_word = ctrl.backward ? upper_half : ~upper_half;

  always_comb
  begin
    next_addr = word_addr;
    if (!same_word)
    begin
      if (!ctrl.backward)
        next_addr = (word_addr == flash_last_addr) ? '0 : word_addr + 1'b1;
      else
        next_addr = (word_addr == '0) ? flash_last_addr : word_addr - 1'b1;
    end
  end

  // Ticks while paused or busy are dropped
  assign tick_ok = sample_tick && ctrl.playing && (state == fetch_idle);

  // Address only moves when idle, so it is steady across a request
  assign flash_address = word_addr;

  // ====================
  // Fetch FSM
  // ====================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state           <= fetch_idle;
      flash_read      <= 1'b0;
      word_addr       <= '0;
      upper_half      <= 1'b0;
      word_held       <= 1'b0;
      restart_pending <= 1'b0;
      sample.valid    <= 1'b0;
    end
    else
    begin
      sample.valid <= 1'b0;

      case (state)
        fetch_idle:
        begin
          if (restart_pending)
          begin
            // First sample of the song in the current direction
            word_addr       <= ctrl.backward ? flash_last_addr : '0;
            upper_half      <= ctrl.backward;
            word_held       <= 1'b0;
            restart_pending <= 1'b0;
          end
          else if (tick_ok)
          begin
            if (word_held)
            begin
              // Other half of the held word, no flash access
              sample.valid <= 1'b1;
              sample.data  <= upper_half ? word_reg[31:24] : word_reg[15:8];
              word_addr    <= next_addr;
              upper_half   <= ~upper_half;
              word_held    <= same_word;
            end
            else
            begin
              flash_read <= 1'b1;
              state      <= fetch_request;
            end
          end
        end

        fetch_request:
        begin
          // Accepted on the first cycle without waitrequest
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= fetch_wait;
          end
        end

        fetch_wait:
        begin
          if (flash_readdatavalid)
          begin
            word_reg     <= flash_readdata;
            sample.valid <= 1'b1;
            sample.data  <= upper_half ? flash_readdata[31:24] : flash_readdata[15:8];
            word_addr    <= next_addr;
            upper_half   <= ~upper_half;
            word_held    <= same_word;
            state        <= fetch_idle;
          end
        end

        default:
        begin
          flash_read <= 1'b0;
          state      <= fetch_idle;
        end
      endcase

      // Held until the FSM is back in idle
      if (ctrl.restart)
        restart_pending <= 1'b1;
    end
  end

endmodule

/* src/sample_rate_gen.sv */
`timescale 1ns/1ns

module sample_rate_gen
  import ipod_pkg::*;
(
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,
  output rate_count_t rate_count,
  output logic        sample_tick
);

  // Cycles left in the current sample period
  rate_count_t tick_cnt;

  // ====================
  // Rate register
  // ====================

  // Smaller count means faster playback
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      rate_count <= rate_default;
    end
    else if (speed_reset)
    begin
      rate_count <= rate_default;
    end
    else if (speed_up)
    begin
      // Clamp at the fast end
      if (rate_count <= rate_min + rate_step)
        rate_count <= rate_min;
      else
        rate_count <= rate_count - rate_step;
    end
    else if (speed_down)
    begin
      // Clamp at the slow end
      if (rate_count >= rate_max - rate_step)
        rate_count <= rate_max;
      else
        rate_count <= rate_count + rate_step;
    end
  end

  // ====================
  // Period counter
  // ====================

  // Reload picks up a new rate only at the period boundary
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_cnt <= rate_default;
    end
    else if (tick_cnt == '0)
    begin
      tick_cnt <= rate_count;
    end
    else
    begin
      tick_cnt <= tick_cnt - 1'b1;
    end
  end

  // One tick per reload, so rate_count+1 cycles apart
  assign sample_tick = (tick_cnt == '0);

endmodule

/* src/player_control.sv */
`timescale 1ns/1ns

module player_control
  import ipod_pkg::*;
(
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  key_event_t key,
  output play_ctrl_t ctrl
);

  // ====================
  // Key decode
  // ====================

  // Any key code other than the five commands is ignored
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      ctrl.playing  <= 1'b0;
      ctrl.backward <= 1'b0;
      ctrl.restart  <= 1'b0;
    end
    else
    begin
      // Restart only lasts one cycle
      ctrl.restart <= 1'b0;

      if (key.valid)
      begin
        case (key.code)
          key_play:
          begin
            ctrl.playing <= 1'b1;
          end
          key_pause:
          begin
            ctrl.playing <= 1'b0;
          end
          key_forward:
          begin
            ctrl.backward <= 1'b0;
          end
          key_backward:
          begin
            ctrl.backward <= 1'b1;
          end
          key_restart:
          begin
            ctrl.restart <= 1'b1;
          end
          default:
          begin
            ctrl.restart <= 1'b0;
          end
        endcase
      end
    end
  end

endmodule

/* src/ipod_pkg.sv */
package ipod_pkg;

  // ====================
  // Widths and types
  // ====================

  // Flash word address and read data
  typedef logic [22:0] flash_addr_t;
  typedef logic [31:0] flash_word_t;

  // Signed upper byte of a 16-bit sample
  typedef logic signed [7:0] audio_sample_t;

  // Extra clock cycles between sample ticks
  typedef logic [12:0] rate_count_t;

  typedef logic [7:0] ascii_t;

  typedef struct packed {
    logic   valid;
    ascii_t code;
  } key_event_t;

  // restart is a single-cycle strobe
  typedef struct packed {
    logic playing;
    logic backward;
    logic restart;
  } play_ctrl_t;

  typedef struct packed {
    logic          valid;
    audio_sample_t data;
  } sample_out_t;

  // Flash read handshake
  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_wait
  } fetch_state_t;

  // ====================
  // Command keys
  // ====================
  localparam ascii_t key_play     = 8'h45;  // 'E'
  localparam ascii_t key_pause    = 8'h44;  // 'D'
  localparam ascii_t key_forward  = 8'h46;  // 'F'
  localparam ascii_t key_backward = 8'h42;  // 'B'
  localparam ascii_t key_restart  = 8'h52;  // 'R'

  // ====================
  // Rate limits
  // ====================

  // Roughly 22 kHz at 50 MHz
  localparam rate_count_t rate_default = 13'd2272;
  localparam rate_count_t rate_step    = 13'd16;
  localparam rate_count_t rate_min     = 13'd64;
  localparam rate_count_t rate_max     = 13'd8000;

  // Last word of the song image
  localparam flash_addr_t flash_last_addr = 23'h7FFFF;

endpackage
